//--- source/usb_bulk_pkg.sv
`default_nettype none

package usb_bulk_pkg;

  typedef logic [7:0]  usb_byte_t;
  typedef logic [3:0]  usb_pid_t;
  typedef logic [6:0]  usb_addr_t;
  typedef logic [3:0]  usb_endp_t;
  typedef logic [15:0] usb_crc16_t;

  // PID nibbles, sent on the wire as {~pid, pid}
  localparam usb_pid_t PID_OUT   = 4'h1;
  localparam usb_pid_t PID_IN    = 4'h9;
  localparam usb_pid_t PID_DATA0 = 4'h3;
  localparam usb_pid_t PID_DATA1 = 4'hB;
  localparam usb_pid_t PID_ACK   = 4'h2;
  localparam usb_pid_t PID_NAK   = 4'hA;

  // Reflected form of the good-packet CRC16 remainder
  localparam usb_crc16_t CRC16_RESIDUE = 16'hB001;

  typedef struct packed {
    usb_byte_t data;
    logic      last;
  } usb_stream_t;

  typedef enum logic [2:0] {
    EV_NONE,
    EV_OUT_TOKEN,
    EV_IN_TOKEN,
    EV_DATA_OK,
    EV_DATA_BAD,
    EV_ACK
  } usb_event_kind_t;

  typedef struct packed {
    usb_event_kind_t kind;
    logic            toggle;
    logic            target;
  } usb_event_t;

  typedef enum logic [1:0] {
    RP_ACK,
    RP_NAK,
    RP_DATA0,
    RP_DATA1
  } usb_reply_kind_t;

  // One byte of CRC16, polynomial 0x8005 processed LSB first
  function automatic usb_crc16_t crc16_step(input usb_crc16_t crc, input usb_byte_t data);
    usb_crc16_t c;
    c = crc ^ {8'h00, data};
    for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ 16'hA001) : (c >> 1);
    end
    return c;
  endfunction

endpackage

`default_nettype wire

//--- source/usb_packet_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module usb_packet_decoder #(
  parameter usb_bulk_pkg::usb_addr_t DEVICE_ADDRESS = 7'd5,
  parameter usb_bulk_pkg::usb_endp_t ENDPOINT       = 4'd1
) (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       rx_valid_i,
  input  usb_bulk_pkg::usb_stream_t rx_stream_i,
  input  wire                       data_en_i,
  output usb_bulk_pkg::usb_event_t  event_o,
  output logic                      fifo_wr_valid_o,
  output usb_bulk_pkg::usb_byte_t   fifo_wr_byte_o,
  output logic                      crc_error_o
);

  typedef enum logic [2:0] {PID, TOKEN1, TOKEN2, PAYLOAD, SKIP} dec_state_t;

  dec_state_t               state_q;
  usb_bulk_pkg::usb_pid_t   pid_q;
  usb_bulk_pkg::usb_addr_t  addr_q;
  logic                     endp0_q;
  usb_bulk_pkg::usb_crc16_t crc_q;
  usb_bulk_pkg::usb_crc16_t crc_next;
  usb_bulk_pkg::usb_byte_t  hold0_q;
  usb_bulk_pkg::usb_byte_t  hold1_q;
  logic [1:0]               held_q;
  usb_bulk_pkg::usb_event_t event_q;
  logic                     crc_error_q;
  logic                     wr_valid_q;
  usb_bulk_pkg::usb_byte_t  wr_byte_q;
  logic                     pid_ok;
  logic                     target;

  assign pid_ok   = rx_stream_i.data[7:4] == ~rx_stream_i.data[3:0];
  assign crc_next = usb_bulk_pkg::crc16_step(crc_q, rx_stream_i.data);
  // Endpoint bit 0 sits in the first token byte, bits 3:1 in the second
  assign target   = (addr_q == DEVICE_ADDRESS) &&
                    ({rx_stream_i.data[2:0], endp0_q} == ENDPOINT);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q     <= PID;
      held_q      <= 2'd0;
      event_q     <= '0;
      crc_error_q <= 1'b0;
      wr_valid_q  <= 1'b0;
    end else begin
      event_q     <= '0;
      crc_error_q <= 1'b0;
      wr_valid_q  <= 1'b0;
      if (rx_valid_i) begin
        case (state_q)
          PID: begin
            held_q <= 2'd0;
            if (rx_stream_i.last) begin
              // Single-byte packets from the host are handshakes
              if (pid_ok && rx_stream_i.data[3:0] == usb_bulk_pkg::PID_ACK) begin
                event_q.kind <= usb_bulk_pkg::EV_ACK;
              end
            end else if (!pid_ok) begin
              state_q <= SKIP;
            end else begin
              case (rx_stream_i.data[3:0])
                usb_bulk_pkg::PID_OUT,
                usb_bulk_pkg::PID_IN:    state_q <= TOKEN1;
                usb_bulk_pkg::PID_DATA0,
                usb_bulk_pkg::PID_DATA1: state_q <= PAYLOAD;
                default:                 state_q <= SKIP;
              endcase
            end
          end
          TOKEN1: begin
            state_q <= rx_stream_i.last ? PID : TOKEN2;
          end
          TOKEN2: begin
            if (rx_stream_i.last) begin
              state_q        <= PID;
              event_q.kind   <= (pid_q == usb_bulk_pkg::PID_IN) ?
                                usb_bulk_pkg::EV_IN_TOKEN : usb_bulk_pkg::EV_OUT_TOKEN;
              event_q.target <= target;
            end else begin
              state_q <= SKIP;
            end
          end
          PAYLOAD: begin
            // The two newest bytes may be the CRC, so only older ones go out
            if (held_q == 2'd2) begin
              wr_valid_q <= data_en_i;
            end else begin
              held_q <= held_q + 2'd1;
            end
            if (rx_stream_i.last) begin
              state_q        <= PID;
              event_q.toggle <= pid_q[3];
              if (crc_next == usb_bulk_pkg::CRC16_RESIDUE) begin
                event_q.kind <= usb_bulk_pkg::EV_DATA_OK;
              end else begin
                event_q.kind <= usb_bulk_pkg::EV_DATA_BAD;
                crc_error_q  <= 1'b1;
              end
            end
          end
          default: begin
            if (rx_stream_i.last) begin
              state_q <= PID;
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rx_valid_i) begin
      if (state_q == PID) begin
        pid_q <= rx_stream_i.data[3:0];
        crc_q <= '1;
      end
      if (state_q == TOKEN1) begin
        addr_q  <= rx_stream_i.data[6:0];
        endp0_q <= rx_stream_i.data[7];
      end
      if (state_q == PAYLOAD) begin
        crc_q     <= crc_next;
        hold0_q   <= rx_stream_i.data;
        hold1_q   <= hold0_q;
        wr_byte_q <= hold1_q;
      end
    end
  end

  assign event_o         = event_q;
  assign fifo_wr_valid_o = wr_valid_q;
  assign fifo_wr_byte_o  = wr_byte_q;
  assign crc_error_o     = crc_error_q;

  // Events only appear right after the closing byte of a packet
  a_event_after_last: assert property (@(posedge clock) disable iff (reset)
    !$past(rx_valid_i && rx_stream_i.last) |-> event_o.kind == usb_bulk_pkg::EV_NONE);

endmodule

`default_nettype wire

//--- source/usb_bulk_transactor.sv
`timescale 1ns/1ps
`default_nettype none

module usb_bulk_transactor (
  input  wire                           clock,
  input  wire                           reset,
  input  usb_bulk_pkg::usb_event_t      event_i,
  output logic                          data_en_o,
  output logic                          fifo_save_o,
  output logic                          fifo_drop_o,
  output logic                          fifo_commit_o,
  output logic                          fifo_rewind_o,
  input  wire                           fifo_avail_i,
  input  wire                           fifo_space_i,
  output logic                          reply_valid_o,
  output usb_bulk_pkg::usb_reply_kind_t reply_kind_o,
  input  wire                           reply_ready_i
);

  typedef enum logic [1:0] {IDLE, OUT_WAIT_DATA, IN_WAIT_ACK} xact_state_t;

  xact_state_t                   state_q;
  logic                          out_toggle_q;
  logic                          in_toggle_q;
  logic                          data_en_q;
  logic                          save_q;
  logic                          drop_q;
  logic                          commit_q;
  logic                          rewind_q;
  logic                          reply_valid_q;
  usb_bulk_pkg::usb_reply_kind_t reply_kind_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q       <= IDLE;
      out_toggle_q  <= 1'b0;
      in_toggle_q   <= 1'b0;
      data_en_q     <= 1'b0;
      save_q        <= 1'b0;
      drop_q        <= 1'b0;
      commit_q      <= 1'b0;
      rewind_q      <= 1'b0;
      reply_valid_q <= 1'b0;
      reply_kind_q  <= usb_bulk_pkg::RP_NAK;
    end else begin
      save_q   <= 1'b0;
      drop_q   <= 1'b0;
      commit_q <= 1'b0;
      rewind_q <= 1'b0;
      if (reply_ready_i) begin
        reply_valid_q <= 1'b0;
      end
      if (event_i.kind != usb_bulk_pkg::EV_NONE) begin
        state_q   <= IDLE;
        data_en_q <= 1'b0;
        // Unacknowledged IN data goes back to the start of its packet
        if (state_q == IN_WAIT_ACK && event_i.kind != usb_bulk_pkg::EV_ACK) begin
          rewind_q <= 1'b1;
        end
        case (event_i.kind)
          usb_bulk_pkg::EV_OUT_TOKEN: begin
            if (event_i.target) begin
              state_q   <= OUT_WAIT_DATA;
              data_en_q <= fifo_space_i;
            end
          end
          usb_bulk_pkg::EV_IN_TOKEN: begin
            if (event_i.target) begin
              reply_valid_q <= 1'b1;
              if (fifo_avail_i) begin
                state_q      <= IN_WAIT_ACK;
                reply_kind_q <= in_toggle_q ? usb_bulk_pkg::RP_DATA1 : usb_bulk_pkg::RP_DATA0;
              end else begin
                reply_kind_q <= usb_bulk_pkg::RP_NAK;
              end
            end
          end
          usb_bulk_pkg::EV_DATA_OK: begin
            if (state_q == OUT_WAIT_DATA) begin
              reply_valid_q <= 1'b1;
              if (!data_en_q) begin
                reply_kind_q <= usb_bulk_pkg::RP_NAK;
              end else if (event_i.toggle == out_toggle_q) begin
                save_q       <= 1'b1;
                out_toggle_q <= ~out_toggle_q;
                reply_kind_q <= usb_bulk_pkg::RP_ACK;
              end else begin
                // Host missed our ACK and resent the packet
                drop_q       <= 1'b1;
                reply_kind_q <= usb_bulk_pkg::RP_ACK;
              end
            end
          end
          usb_bulk_pkg::EV_DATA_BAD: begin
            if (state_q == OUT_WAIT_DATA && data_en_q) begin
              drop_q <= 1'b1;
            end
          end
          usb_bulk_pkg::EV_ACK: begin
            if (state_q == IN_WAIT_ACK) begin
              commit_q    <= 1'b1;
              in_toggle_q <= ~in_toggle_q;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  assign data_en_o     = data_en_q;
  assign fifo_save_o   = save_q;
  assign fifo_drop_o   = drop_q;
  assign fifo_commit_o = commit_q;
  assign fifo_rewind_o = rewind_q;
  assign reply_valid_o = reply_valid_q;
  assign reply_kind_o  = reply_kind_q;

  a_save_drop_excl: assert property (@(posedge clock) disable iff (reset)
    !(fifo_save_o && fifo_drop_o));

endmodule

`default_nettype wire

//--- source/usb_packet_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module usb_packet_fifo #(
  parameter int DEPTH      = 2048,
  parameter int MAX_PACKET = 512
) (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       wr_valid_i,
  input  usb_bulk_pkg::usb_byte_t   wr_byte_i,
  input  wire                       save_i,
  input  wire                       drop_i,
  output logic                      space_ok_o,
  output logic                      rd_valid_o,
  input  wire                       rd_ready_i,
  output usb_bulk_pkg::usb_stream_t rd_stream_o,
  input  wire                       commit_i,
  input  wire                       rewind_i,
  output logic                      packet_avail_o
);

  localparam int AW     = $clog2(DEPTH);
  localparam int LQ_AW  = 4;
  localparam int LQ_LEN = 1 << LQ_AW;

  typedef logic [AW:0] ptr_t;

  usb_bulk_pkg::usb_byte_t mem [DEPTH];
  ptr_t                    lq_end [LQ_LEN];

  ptr_t             wr_ptr_q;
  ptr_t             wr_cmt_q;
  ptr_t             rd_ptr_q;
  ptr_t             rd_cmt_q;
  ptr_t             fill;
  logic [LQ_AW-1:0] lq_head_q;
  logic [LQ_AW-1:0] lq_tail_q;
  logic [LQ_AW:0]   lq_count_q;
  logic             push;
  logic             pop;

  // A save with nothing written since the last boundary adds no packet
  assign push = save_i && (wr_ptr_q != wr_cmt_q);
  assign pop  = commit_i && (lq_count_q != '0);
  assign fill = wr_ptr_q - rd_cmt_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q   <= '0;
      wr_cmt_q   <= '0;
      rd_ptr_q   <= '0;
      rd_cmt_q   <= '0;
      lq_head_q  <= '0;
      lq_tail_q  <= '0;
      lq_count_q <= '0;
    end else begin
      if (drop_i) begin
        wr_ptr_q <= wr_cmt_q;
      end else if (wr_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (push) begin
        wr_cmt_q  <= wr_ptr_q;
        lq_tail_q <= lq_tail_q + 1'b1;
      end
      if (rewind_i) begin
        rd_ptr_q <= rd_cmt_q;
      end else if (rd_valid_o && rd_ready_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_cmt_q  <= rd_ptr_q;
        lq_head_q <= lq_head_q + 1'b1;
      end
      lq_count_q <= lq_count_q + push - pop;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_valid_i) begin
      mem[wr_ptr_q[AW-1:0]] <= wr_byte_i;
    end
    if (push) begin
      lq_end[lq_tail_q] <= wr_ptr_q - 1'b1;
    end
  end

  // Reads stay inside saved packets, the head entry marks the final byte
  assign rd_valid_o       = rd_ptr_q != wr_cmt_q;
  assign rd_stream_o.data = mem[rd_ptr_q[AW-1:0]];
  assign rd_stream_o.last = rd_ptr_q == lq_end[lq_head_q];

  assign space_ok_o     = (fill <= ptr_t'(DEPTH - MAX_PACKET)) &&
                          (lq_count_q != (LQ_AW+1)'(LQ_LEN));
  assign packet_avail_o = lq_count_q != '0;

  // Writes only happen after space was reserved at token time
  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    wr_valid_i |-> fill < ptr_t'(DEPTH));

endmodule

`default_nettype wire

//--- source/usb_packet_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module usb_packet_encoder (
  input  wire                           clock,
  input  wire                           reset,
  input  wire                           reply_valid_i,
  input  usb_bulk_pkg::usb_reply_kind_t reply_kind_i,
  output logic                          reply_ready_o,
  input  wire                           fifo_rd_valid_i,
  output logic                          fifo_rd_ready_o,
  input  usb_bulk_pkg::usb_stream_t     fifo_rd_stream_i,
  output logic                          tx_valid_o,
  input  wire                           tx_ready_i,
  output usb_bulk_pkg::usb_stream_t     tx_stream_o,
  output logic                          busy_o
);

  typedef enum logic [2:0] {IDLE, PID, PAYLOAD, CRC_LO, CRC_HI} enc_state_t;

  enc_state_t                    state_q;
  usb_bulk_pkg::usb_reply_kind_t kind_q;
  usb_bulk_pkg::usb_crc16_t      crc_q;
  logic                          tx_valid_q;
  usb_bulk_pkg::usb_stream_t     tx_stream_q;
  usb_bulk_pkg::usb_pid_t        pid_w;
  logic                          handshake;
  logic                          load;

  always_comb begin
    case (kind_q)
      usb_bulk_pkg::RP_ACK:   pid_w = usb_bulk_pkg::PID_ACK;
      usb_bulk_pkg::RP_NAK:   pid_w = usb_bulk_pkg::PID_NAK;
      usb_bulk_pkg::RP_DATA0: pid_w = usb_bulk_pkg::PID_DATA0;
      default:                pid_w = usb_bulk_pkg::PID_DATA1;
    endcase
  end

  assign handshake = (kind_q == usb_bulk_pkg::RP_ACK) || (kind_q == usb_bulk_pkg::RP_NAK);
  // Output register can take a new beat when empty or being drained
  assign load      = !tx_valid_q || tx_ready_i;

  assign busy_o          = (state_q != IDLE) || tx_valid_q;
  assign reply_ready_o   = !busy_o;
  assign fifo_rd_ready_o = (state_q == PAYLOAD) && load;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= IDLE;
      tx_valid_q <= 1'b0;
    end else begin
      if (tx_ready_i) begin
        tx_valid_q <= 1'b0;
      end
      case (state_q)
        IDLE: begin
          if (reply_valid_i && reply_ready_o) begin
            state_q <= PID;
          end
        end
        PID: begin
          if (load) begin
            tx_valid_q <= 1'b1;
            state_q    <= handshake ? IDLE : PAYLOAD;
          end
        end
        PAYLOAD: begin
          if (fifo_rd_valid_i && fifo_rd_ready_o) begin
            tx_valid_q <= 1'b1;
            if (fifo_rd_stream_i.last) begin
              state_q <= CRC_LO;
            end
          end
        end
        CRC_LO: begin
          if (load) begin
            tx_valid_q <= 1'b1;
            state_q    <= CRC_HI;
          end
        end
        default: begin
          if (load) begin
            tx_valid_q <= 1'b1;
            state_q    <= IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == IDLE && reply_valid_i && reply_ready_o) begin
      kind_q <= reply_kind_i;
      crc_q  <= '1;
    end
    if (state_q == PID && load) begin
      tx_stream_q.data <= {~pid_w, pid_w};
      tx_stream_q.last <= handshake;
    end
    if (state_q == PAYLOAD && fifo_rd_valid_i && fifo_rd_ready_o) begin
      tx_stream_q.data <= fifo_rd_stream_i.data;
      tx_stream_q.last <= 1'b0;
      crc_q            <= usb_bulk_pkg::crc16_step(crc_q, fifo_rd_stream_i.data);
    end
    // CRC goes out inverted, low byte first
    if (state_q == CRC_LO && load) begin
      tx_stream_q.data <= ~crc_q[7:0];
      tx_stream_q.last <= 1'b0;
    end
    if (state_q == CRC_HI && load) begin
      tx_stream_q.data <= ~crc_q[15:8];
      tx_stream_q.last <= 1'b1;
    end
  end

  assign tx_valid_o  = tx_valid_q;
  assign tx_stream_o = tx_stream_q;

  a_tx_hold: assert property (@(posedge clock) disable iff (reset)
    tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_stream_o));

endmodule

`default_nettype wire

//--- source/usb_bulk_loopback_top.sv
`timescale 1ns/1ps
`default_nettype none

module usb_bulk_loopback_top #(
  parameter usb_bulk_pkg::usb_addr_t DEVICE_ADDRESS = 7'd5,
  parameter usb_bulk_pkg::usb_endp_t ENDPOINT       = 4'd1,
  parameter int                      FIFO_DEPTH     = 2048,
  parameter int                      MAX_PACKET     = 512
) (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       rx_valid_i,
  output logic                      rx_ready_o,
  input  usb_bulk_pkg::usb_stream_t rx_stream_i,
  output logic                      tx_valid_o,
  input  wire                       tx_ready_i,
  output usb_bulk_pkg::usb_stream_t tx_stream_o,
  output logic                      crc_error_o,
  output logic                      in_ready_o
);

  usb_bulk_pkg::usb_event_t      event_w;
  usb_bulk_pkg::usb_byte_t       fifo_wr_byte;
  usb_bulk_pkg::usb_stream_t     fifo_rd_stream;
  usb_bulk_pkg::usb_reply_kind_t reply_kind;
  logic fifo_wr_valid, data_en, fifo_save, fifo_drop, fifo_commit, fifo_rewind;
  logic fifo_avail, fifo_space, fifo_rd_valid, fifo_rd_ready;
  logic reply_valid, reply_ready, enc_busy;

  // Half duplex, the host link is held off while a reply is going out
  assign rx_ready_o = !enc_busy;
  assign in_ready_o = fifo_avail;

  usb_packet_decoder #(
    .DEVICE_ADDRESS(DEVICE_ADDRESS),
    .ENDPOINT      (ENDPOINT)
  ) decoder0 (
    .clock          (clock),
    .reset          (reset),
    .rx_valid_i     (rx_valid_i && rx_ready_o),
    .rx_stream_i    (rx_stream_i),
    .data_en_i      (data_en),
    .event_o        (event_w),
    .fifo_wr_valid_o(fifo_wr_valid),
    .fifo_wr_byte_o (fifo_wr_byte),
    .crc_error_o    (crc_error_o)
  );

  usb_bulk_transactor xact0 (
    .clock        (clock),
    .reset        (reset),
    .event_i      (event_w),
    .data_en_o    (data_en),
    .fifo_save_o  (fifo_save),
    .fifo_drop_o  (fifo_drop),
    .fifo_commit_o(fifo_commit),
    .fifo_rewind_o(fifo_rewind),
    .fifo_avail_i (fifo_avail),
    .fifo_space_i (fifo_space),
    .reply_valid_o(reply_valid),
    .reply_kind_o (reply_kind),
    .reply_ready_i(reply_ready)
  );

  usb_packet_fifo #(
    .DEPTH     (FIFO_DEPTH),
    .MAX_PACKET(MAX_PACKET)
  ) fifo0 (
    .clock         (clock),
    .reset         (reset),
    .wr_valid_i    (fifo_wr_valid),
    .wr_byte_i     (fifo_wr_byte),
    .save_i        (fifo_save),
    .drop_i        (fifo_drop),
    .space_ok_o    (fifo_space),
    .rd_valid_o    (fifo_rd_valid),
    .rd_ready_i    (fifo_rd_ready),
    .rd_stream_o   (fifo_rd_stream),
    .commit_i      (fifo_commit),
    .rewind_i      (fifo_rewind),
    .packet_avail_o(fifo_avail)
  );

  usb_packet_encoder encoder0 (
    .clock           (clock),
    .reset           (reset),
    .reply_valid_i   (reply_valid),
    .reply_kind_i    (reply_kind),
    .reply_ready_o   (reply_ready),
    .fifo_rd_valid_i (fifo_rd_valid),
    .fifo_rd_ready_o (fifo_rd_ready),
    .fifo_rd_stream_i(fifo_rd_stream),
    .tx_valid_o      (tx_valid_o),
    .tx_ready_i      (tx_ready_i),
    .tx_stream_o     (tx_stream_o),
    .busy_o          (enc_busy)
  );

endmodule

`default_nettype wire

//--- dv/usb_bulk_loopback_tb.sv
`timescale 1ns/1ps
`default_nettype none

module usb_bulk_loopback_tb;

  localparam int REPLY_TIMEOUT = 2000;
  localparam int QUIET_CYCLES  = 40;

  logic                      clock;
  logic                      reset;
  logic                      rx_valid_i;
  logic                      rx_ready_o;
  usb_bulk_pkg::usb_stream_t rx_stream_i;
  logic                      tx_valid_o;
  logic                      tx_ready_i;
  usb_bulk_pkg::usb_stream_t tx_stream_o;
  logic                      crc_error_o;
  logic                      in_ready_o;

  // Bytes of the record being collected from the vector file
  logic [7:0] rec_bytes [0:1023];
  int         rec_len        = 0;
  int         rec_value      = 0;
  string      rec_kind       = "";
  int         value_errors   = 0;
  int         timeout_errors = 0;
  int         other_errors   = 0;
  int         checks_done    = 0;
  int         crc_pulses     = 0;

  usb_bulk_loopback_top dut0 (
    .clock      (clock),
    .reset      (reset),
    .rx_valid_i (rx_valid_i),
    .rx_ready_o (rx_ready_o),
    .rx_stream_i(rx_stream_i),
    .tx_valid_o (tx_valid_o),
    .tx_ready_i (tx_ready_i),
    .tx_stream_o(tx_stream_o),
    .crc_error_o(crc_error_o),
    .in_ready_o (in_ready_o)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // One-cycle pulse, so each falling edge sees it at most once
  always @(negedge clock) begin
    if (!reset && crc_error_o) begin
      crc_pulses++;
    end
  end

  task automatic append_byte(input logic [7:0] value);
    if (rec_len < 1024) begin
      rec_bytes[rec_len] = value;
      rec_len++;
    end
  endtask

  // Serial CRC16 over everything after the PID, high register bit is the feedback tap
  task automatic append_crc(input bit corrupt);
    logic [15:0] crc;
    logic [15:0] sent;
    logic        feedback;
    crc = 16'hFFFF;
    for (int i = 1; i < rec_len; i++) begin
      for (int b = 0; b < 8; b++) begin
        feedback = rec_bytes[i][b] ^ crc[15];
        crc = {crc[14:0], 1'b0};
        if (feedback) begin
          crc = crc ^ 16'h8005;
        end
      end
    end
    // Inverted remainder leaves MSB first, so the LSB-first byte stream sees it reversed
    crc = ~crc;
    for (int k = 0; k < 16; k++) begin
      sent[k] = crc[15-k];
    end
    if (corrupt) begin
      sent = sent ^ 16'h0001;
    end
    append_byte(sent[7:0]);
    append_byte(sent[15:8]);
  endtask

  task automatic send_host_packet();
    int waited;
    bit stuck;
    stuck = 1'b0;
    for (int i = 0; i < rec_len && !stuck; i++) begin
      @(negedge clock);
      rx_valid_i       = 1'b1;
      rx_stream_i.data = rec_bytes[i];
      rx_stream_i.last = (i == rec_len - 1);
      waited = 0;
      while (!rx_ready_o && waited < REPLY_TIMEOUT) begin
        @(negedge clock);
        waited++;
      end
      if (!rx_ready_o) begin
        $display("device did not accept host byte %0d", i);
        timeout_errors++;
        stuck = 1'b1;
      end
    end
    @(negedge clock);
    rx_valid_i  = 1'b0;
    rx_stream_i = '0;
  endtask

  task automatic expect_device_packet();
    int   idx;
    int   waited;
    logic last_exp;
    idx    = 0;
    waited = 0;
    checks_done++;
    while (idx < rec_len && waited < REPLY_TIMEOUT) begin
      @(negedge clock);
      tx_ready_i = ($urandom % 4) != 0;
      // Valid and ready both hold until the next rising edge, which takes this beat
      if (tx_valid_o && tx_ready_i) begin
        last_exp = (idx == rec_len - 1);
        if (tx_stream_o.data !== rec_bytes[idx]) begin
          $display("error at %0t ns: byte %0d expected %02h observed %02h",
                   $time, idx, rec_bytes[idx], tx_stream_o.data);
          value_errors++;
        end
        if (tx_stream_o.last !== last_exp) begin
          $display("error at %0t ns: byte %0d last expected %0b observed %0b",
                   $time, idx, last_exp, tx_stream_o.last);
          value_errors++;
        end
        idx++;
        waited = 0;
      end else begin
        waited++;
      end
    end
    if (idx < rec_len) begin
      $display("no reply from device");
      timeout_errors++;
    end
    @(negedge clock);
    tx_ready_i = 1'b0;
  endtask

  task automatic expect_silence();
    bit seen;
    seen = 1'b0;
    checks_done++;
    tx_ready_i = 1'b0;
    for (int i = 0; i < QUIET_CYCLES && !seen; i++) begin
      @(negedge clock);
      if (tx_valid_o) begin
        $display("error at %0t ns: device sent %02h where no reply was expected",
                 $time, tx_stream_o.data);
        value_errors++;
        seen = 1'b1;
      end
    end
  endtask

  task automatic check_crc_errors(input int expected);
    @(negedge clock);
    checks_done++;
    if (crc_pulses != expected) begin
      $display("error at %0t ns: crc_error count expected %0d observed %0d",
               $time, expected, crc_pulses);
      value_errors++;
    end
  endtask

  task automatic check_in_ready(input int expected);
    @(negedge clock);
    checks_done++;
    if (in_ready_o !== expected[0]) begin
      $display("error at %0t ns: in_ready expected %0d observed %0b",
               $time, expected, in_ready_o);
      value_errors++;
    end
  endtask

  task automatic run_record();
    if (rec_kind == "H") begin
      send_host_packet();
    end else if (rec_kind == "D") begin
      expect_device_packet();
    end else if (rec_kind == "N") begin
      expect_silence();
    end else if (rec_kind == "C") begin
      check_crc_errors(rec_value);
    end else if (rec_kind == "I") begin
      check_in_ready(rec_value);
    end
  endtask

  initial begin : main_flow
    int          fd;
    int          rnd;
    int          code;
    int          count;
    string       tok;
    string       rest;
    logic [31:0] value;
    logic [7:0]  ramp_byte;
    rnd         = $urandom(55);
    reset       = 1'b1;
    rx_valid_i  = 1'b0;
    rx_stream_i = '0;
    tx_ready_i  = 1'b0;
    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    fd = $fopen("dv/usb_bulk_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/usb_bulk_vectors.txt");
      other_errors++;
    end else begin
      // A record runs once the keyword of the next one is read
      code = $fscanf(fd, "%s", tok);
      while (code == 1) begin
        if (tok.substr(0, 0) == "#") begin
          code = $fgets(rest, fd);
        end else if (tok == "H" || tok == "D" || tok == "N" || tok == "C" || tok == "I") begin
          run_record();
          rec_kind = tok;
          rec_len  = 0;
          if (tok == "C" || tok == "I") begin
            code = $fscanf(fd, "%d", rec_value);
          end
        end else if (tok == "CRC") begin
          append_crc(1'b0);
        end else if (tok == "BAD") begin
          append_crc(1'b1);
        end else if (tok == "RAMP") begin
          code      = $fscanf(fd, "%h %d", value, count);
          ramp_byte = value[7:0];
          for (int i = 0; i < count; i++) begin
            append_byte(ramp_byte);
            ramp_byte = ramp_byte + 8'd1;
          end
        end else if ($sscanf(tok, "%h", value) == 1) begin
          append_byte(value[7:0]);
        end else begin
          $display("unreadable token %s in vector file", tok);
          other_errors++;
        end
        code = $fscanf(fd, "%s", tok);
      end
      run_record();
      $fclose(fd);
    end

    if (checks_done == 0) begin
      $display("no device responses were checked");
      other_errors++;
    end
    $display("errors: %0d value, %0d timeout, %0d other",
             value_errors, timeout_errors, other_errors);
    if (value_errors + timeout_errors + other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
source/usb_bulk_pkg.sv
source/usb_packet_decoder.sv
source/usb_bulk_transactor.sv
source/usb_packet_fifo.sv
source/usb_packet_encoder.sv
source/usb_bulk_loopback_top.sv
dv/usb_bulk_loopback_tb.sv

//--- dv/usb_bulk_vectors.txt
# Records: H host packet, D expected device packet, N no reply expected,
# C expected crc_error total (decimal), I expected in_ready level. Bytes are hex.
# CRC appends the data CRC16, BAD a corrupted CRC16, RAMP start(hex) count(dec) a byte ramp.
# Tokens for address 5 endpoint 1 are 85 00, the token CRC5 bits are left at zero.
I 0  C 0
# OUT with DATA0 is acknowledged and the packet becomes readable
H E1 85 00  H C3 01 02 03 04 CRC  D D2  I 1
# IN returns it as DATA0, the host ACK releases it, then nothing is left
H 69 85 00  D C3 01 02 03 04 CRC  H D2
H 69 85 00  D 5A  I 0
# IN repeated without ACK resends the same DATA1 packet
H E1 85 00  H 4B 10 20 30 CRC  D D2
H 69 85 00  D 4B 10 20 30 CRC
H 69 85 00  D 4B 10 20 30 CRC  H D2
H 69 85 00  D 5A
# Duplicate OUT is acknowledged but stored once
H E1 85 00  H C3 AA BB CRC  D D2
H E1 85 00  H C3 AA BB CRC  D D2
H 69 85 00  D C3 AA BB CRC  H D2
H 69 85 00  D 5A  C 0
# Corrupted CRC gets no reply
H E1 85 00  H 4B 55 66 BAD  N  C 1
# Other address or endpoint is ignored
H E1 86 00  H 4B 11 22 CRC  N
H E1 86 00  H 4B 11 22 BAD  N  C 2
H 69 86 00  N
H 69 05 01  N  I 0
# Long packets under tx back-pressure
H E1 85 00  H 4B RAMP 00 64 CRC  D D2
H E1 85 00  H C3 RAMP 80 64 CRC  D D2
H 69 85 00  D 4B RAMP 00 64 CRC  H D2
H 69 85 00  D C3 RAMP 80 64 CRC  H D2
H 69 85 00  D 5A  I 0  C 2
